// ==== dv/tb_clk_gen.sv ====
/*
 * tb_clk_gen
 * 4 ns testbench clock, reset held for the first 16 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic mclk,
    output logic rst
);

    initial begin
        mclk = 1'b0;
        forever #2 mclk = ~mclk;        // 250 MHz
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge mclk);
        @(negedge mclk);
        rst = 1'b0;                     // release away from the active edge
    end

endmodule

`default_nettype wire

// ==== dv/tb_cmd_seq_mux.sv ====
/*
 * tb_cmd_seq_mux
 * channel and bus models, status ring model, assertion checks on the mux
 */
`timescale 1ns/1ps
`default_nettype none

`include "cmd_seq_consts.svh"

module tb_cmd_seq_mux;

    localparam int NCH        = `CSM_NUM_CHN;
    localparam int NW         = 10;                      // writes per channel per phase
    localparam int TOTAL_WR   = 2 * NCH * NW;
    localparam int WD_CYCLES  = TOTAL_WR * 40 + 2000;

    logic                                 mclk;
    logic                                 rst;
    logic [7:0]                           cmd_ad;
    logic                                 cmd_stb;
    logic [7:0]                           status_ad;
    logic                                 status_rq;
    logic                                 status_start;
    logic [NCH-1:0][3:0]                  frame_num;
    cmd_seq_pkg::seq_wr_t [NCH-1:0]       chn_wr;
    logic [NCH-1:0]                       wr_en;
    logic [NCH-1:0]                       ackn;
    cmd_seq_pkg::seq_wr_t                 out_wr;
    logic                                 wr_en_out;
    logic                                 ackn_out;

    cmd_seq_pkg::seq_wr_t wr_all [NCH][2*NW];            // per channel write queues
    int             drv_idx [NCH];                       // next write to offer
    int             chk_idx [NCH];                       // next write expected on out_wr
    int             drv_lim;                             // writes released so far
    bit             gap_mode;                            // random idle gaps on channels
    bit             bus_run;
    logic [31:0]    lfsr = 32'h2785_d297;
    cmd_seq_pkg::seq_wr_t out_wr_q;
    logic [NCH-1:0] ackn_q;
    int             last_chn;
    bit             all_busy_q;                          // all four requesting at grant edge
    int             grant_cnt = 0;
    int             acc_cnt = 0;
    int             err_out = 0;                         // data and order
    int             err_proto = 0;                       // handshake rules
    int             err_seq = 0;                         // status and end checks

    tb_clk_gen u_clk_gen (.mclk(mclk), .rst(rst));

    cmd_seq_mux UUT (
        .mclk(mclk), .rst(rst),
        .cmd_ad(cmd_ad), .cmd_stb(cmd_stb),
        .status_ad(status_ad), .status_rq(status_rq), .status_start(status_start),
        .frame_num(frame_num),
        .chn_wr(chn_wr), .wr_en(wr_en), .ackn(ackn),
        .out_wr(out_wr), .wr_en_out(wr_en_out), .ackn_out(ackn_out)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};                   // one step per bit
        end
        return v;
    endfunction

    // frames 3..0 with any_req and wr_en_out idle
    function automatic logic [17:0] make_payload();
        return {frame_num, 1'b0, 1'b0};
    endfunction

    function automatic bit drained();
        bit d;
        d = (wr_en == '0) && !wr_en_out;
        for (int c = 0; c < NCH; c++) begin
            if (drv_idx[c] != drv_lim) d = 1'b0;
        end
        return d;
    endfunction

    // channel sources and downstream sink on the falling edge
    initial begin : chan_bus_model
        wr_en    = '0;
        chn_wr   = '0;
        ackn_out = 1'b0;
        for (int c = 0; c < NCH; c++) drv_idx[c] = 0;
        forever begin
            @(negedge mclk);
            if (!rst) begin
                for (int c = 0; c < NCH; c++) begin
                    if (ackn[c]) begin
                        drv_idx[c] = drv_idx[c] + 1;     // taken so move on
                        wr_en[c]   = 1'b0;
                    end
                    if (!wr_en[c] && bus_run && drv_idx[c] < drv_lim) begin
                        if (!gap_mode || take_bits(1) == 32'd1) begin
                            chn_wr[c] = wr_all[c][drv_idx[c]];
                            wr_en[c]  = 1'b1;
                        end
                    end
                end
                ackn_out = bus_run ? (take_bits(2) != 32'd0) : 1'b0;  // ~75% ready
            end
        end
    end

    always @(posedge mclk) begin
        out_wr_q <= out_wr;
        ackn_q   <= ackn;
    end

    // integrity and round robin order on each ackn pulse
    always @(posedge mclk) begin : grant_monitor
        int c;
        c = -1;
        if (rst) begin
            last_chn   = NCH - 1;
            all_busy_q = 1'b0;
        end else begin
            for (int i = 0; i < NCH; i++) begin
                if (ackn[i]) c = i;
            end
            if (c >= 0) begin
                if (chk_idx[c] >= drv_lim) begin
                    err_out++;
                    $display("channel %0d acknowledged with no write queued", c);
                end else begin
                    assert (out_wr == wr_all[c][chk_idx[c]]) else begin
                        err_out++;
                        $display("[ERROR] out_wr on ch%0d: got %h expected %h",
                                 c, out_wr, wr_all[c][chk_idx[c]]);
                    end
                    chk_idx[c] = chk_idx[c] + 1;
                end
                if (grant_cnt == 0 || all_busy_q) begin
                    assert (c == (last_chn + 1) % NCH) else begin
                        err_out++;
                        $display("[ERROR] ackn order: got %h expected %h",
                                 ackn, 4'b0001 << ((last_chn + 1) % NCH));
                    end
                end
                last_chn  = c;
                grant_cnt = grant_cnt + 1;
            end
            all_busy_q = (wr_en == 4'hf);                // for the next pulse
            if (wr_en_out && ackn_out) acc_cnt = acc_cnt + 1;
        end
    end

    initial begin
        for (int c = 0; c < NCH; c++) chk_idx[c] = 0;
    end

    a_valid_hold: assert property (@(posedge mclk) disable iff (rst)
        (wr_en_out && !ackn_out) |=> wr_en_out)
        else begin
            err_proto++;
            $display("wr_en_out dropped without ackn_out");
        end

    a_data_hold: assert property (@(posedge mclk) disable iff (rst)
        (wr_en_out && !ackn_out) |=> $stable(out_wr))
        else begin
            err_proto++;
            $display("[ERROR] out_wr under back-pressure: was %h now %h", out_wr_q, out_wr);
        end

    a_no_ackn_bp: assert property (@(posedge mclk) disable iff (rst)
        (wr_en_out && !ackn_out) |=> (ackn == '0))
        else begin
            err_proto++;
            $display("[ERROR] ackn under back-pressure: %h expected %h", ackn, 4'h0);
        end

    a_ackn_pulse: assert property (@(posedge mclk) disable iff (rst)
        (ackn != '0) |=> ((ackn & $past(ackn)) == '0))
        else begin
            err_proto++;
            $display("[ERROR] ackn longer than one cycle: was %h now %h", ackn_q, ackn);
        end

    a_ackn_onehot: assert property (@(posedge mclk) disable iff (rst) $onehot0(ackn))
        else begin
            err_proto++;
            $display("[ERROR] ackn not one-hot: %h", ackn);
        end

    a_status_addr: assert property (@(posedge mclk) disable iff (rst)
        status_rq |-> (status_ad == `CSM_STATUS_ADDR))
        else begin
            err_proto++;
            $display("[ERROR] status_ad during request: got %h expected %h",
                     status_ad, `CSM_STATUS_ADDR);
        end

    a_rq_hold: assert property (@(posedge mclk) disable iff (rst)
        (status_rq && !status_start) |=> status_rq)
        else begin
            err_proto++;
            $display("status_rq withdrawn before status_start");
        end

    // fill the next NW slots per channel and let the models run until drained
    task run_phase(input bit gaps);
        cmd_seq_pkg::seq_wr_t w;
        for (int c = 0; c < NCH; c++) begin
            for (int i = 0; i < NW; i++) begin
                w.waddr = `CSM_WADDR_BITS'(take_bits(`CSM_WADDR_BITS));
                w.wdata = take_bits(32);
                wr_all[c][drv_lim + i] = w;
            end
        end
        @(posedge mclk);                                 // models see it next fall
        gap_mode = gaps;
        drv_lim  = drv_lim + NW;
        bus_run  = 1'b1;
        @(negedge mclk);
        while (!drained()) @(negedge mclk);
        @(posedge mclk);
        bus_run = 1'b0;
    endtask

    // addr lo with strobe, addr hi, data
    task send_cmd(input logic [15:0] addr, input logic [7:0] data);
        @(negedge mclk);
        cmd_ad  = addr[7:0];
        cmd_stb = 1'b1;
        @(negedge mclk);
        cmd_ad  = addr[15:8];
        cmd_stb = 1'b0;
        @(negedge mclk);
        cmd_ad  = data;
        @(negedge mclk);
        cmd_ad  = 8'h00;
    endtask

    // ring model waits for request and accepts after a random delay
    task collect_packet(input logic [17:0] pl, input logic [5:0] seq);
        logic [7:0] exp_b [3];
        int         waited;
        int         lat;
        exp_b[0] = {seq, pl[1:0]};
        exp_b[1] = pl[9:2];
        exp_b[2] = pl[17:10];
        waited   = 0;
        while (!status_rq && waited < 50) begin
            @(negedge mclk);
            waited++;
        end
        if (!status_rq) begin
            err_seq++;
            $display("no status request within 50 cycles");
        end else begin
            lat = take_bits(3);
            repeat (lat) @(negedge mclk);
            status_start = 1'b1;
            @(negedge mclk);
            status_start = 1'b0;
            for (int i = 0; i < 3; i++) begin
                if (i > 0) @(negedge mclk);
                assert (status_ad == exp_b[i]) else begin
                    err_seq++;
                    $display("[ERROR] status_ad byte %0d: got %h expected %h",
                             i + 1, status_ad, exp_b[i]);
                end
            end
        end
    endtask

    task expect_quiet(input int n);
        repeat (n) begin
            @(negedge mclk);
            assert (!status_rq) else begin
                err_seq++;
                $display("status_rq raised where no packet was due");
            end
        end
    endtask

    initial begin : watchdog
        repeat (WD_CYCLES) @(posedge mclk);
        $display("Timeout: run did not finish within %0d cycles", WD_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin : main_seq
        logic [5:0] seq;
        logic [3:0] nv;
        int         k;
        int         ch;
        int         total;
        cmd_ad       = 8'h00;
        cmd_stb      = 1'b0;
        status_start = 1'b0;
        drv_lim      = 0;
        gap_mode     = 1'b0;
        bus_run      = 1'b0;
        for (int c = 0; c < NCH; c++) frame_num[c] = 4'(take_bits(4));
        wait (!rst);
        run_phase(1'b0);                                 // continuous requests
        run_phase(1'b1);                                 // sparse requests
        seq = 6'(take_bits(6));
        send_cmd(`CSM_CMD_ADDR, {seq, cmd_seq_pkg::STATUS_ONCE});
        collect_packet(make_payload(), seq);
        expect_quiet(20);                                // once falls back to off
        k = take_bits(4) % 11;                           // a bit inside the mask
        send_cmd(`CSM_CMD_ADDR ^ (16'h0001 << k), {seq, cmd_seq_pkg::STATUS_ONCE});
        expect_quiet(20);
        seq = 6'(take_bits(6));
        send_cmd(`CSM_CMD_ADDR, {seq, cmd_seq_pkg::STATUS_AUTO});
        collect_packet(make_payload(), seq);
        for (int n = 0; n < 4; n++) begin
            ch = take_bits(2);
            nv = 4'(take_bits(4));
            if (nv == frame_num[ch]) nv = nv + 4'd1;     // force a change
            @(negedge mclk);
            frame_num[ch] = nv;
            collect_packet(make_payload(), seq);
        end
        expect_quiet(20);                                // no packet without a change
        send_cmd(`CSM_CMD_ADDR, {6'd0, cmd_seq_pkg::STATUS_OFF});
        @(negedge mclk);
        frame_num[0] = frame_num[0] + 4'd1;              // off ignores payload moves
        expect_quiet(10);
        for (int c = 0; c < NCH; c++) begin
            if (chk_idx[c] != drv_lim) begin
                err_seq++;
                $display("channel %0d: %0d of %0d writes reached out_wr",
                         c, chk_idx[c], drv_lim);
            end
        end
        if (grant_cnt != TOTAL_WR || acc_cnt != TOTAL_WR) begin
            err_seq++;
            $display("write counts off: %0d grants, %0d accepted, %0d sent",
                     grant_cnt, acc_cnt, TOTAL_WR);
        end
        total = err_out + err_proto + err_seq;
        $display("Error counts: output %0d, protocol %0d, sequence %0d, total %0d",
                 err_out, err_proto, err_seq, total);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
src/cmd_seq_pkg.sv
src/cmd_deser.sv
src/cmd_seq_arbiter.sv
src/status_generate.sv
src/cmd_seq_mux.sv
dv/tb_clk_gen.sv
dv/tb_cmd_seq_mux.sv

// ==== include/cmd_seq_consts.svh ====
/*
 * cmd_seq_mux constants
 * command address and mask, status address, write widths, channel count
 */
`ifndef CMD_SEQ_CONSTS_SVH
`define CMD_SEQ_CONSTS_SVH

// command port address of this block, status control only
`define CSM_CMD_ADDR     16'h0702
`define CSM_CMD_MASK     16'h07ff  // bits taking part in address compare

// first byte of every status packet
`define CSM_STATUS_ADDR  8'h38

// sequencer write address width
`define CSM_WADDR_BITS   14

// sensor channels feeding the mux
`define CSM_NUM_CHN      4

`endif

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the cmd_seq_mux testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_cmd_seq_mux \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation FAILED, see sim.log"
    exit 1
fi
echo "simulation passed"

// ==== src/cmd_deser.sv ====
/*
 * cmd_deser
 * collects a three byte command (addr lo, addr hi, data) and filters on address
 */
`timescale 1ns/1ps
`default_nettype none

`include "cmd_seq_consts.svh"

module cmd_deser (
    input  logic       mclk,
    input  logic       rst,
    input  logic [7:0] cmd_ad,    // byte stream with addr lo first
    input  logic       cmd_stb,   // marks the addr lo byte
    output logic [7:0] cmd_data,  // data of the last matching command
    output logic       cmd_we     // one cycle pulse after the data byte
);

    cmd_seq_pkg::deser_state_e state;

    logic [7:0]  addr_lo;   // held until addr hi arrives
    logic [15:0] addr_full; // assembled command address
    logic        addr_hit;  // masked compare result
    logic        match_r;   // address matched, waiting for data

    assign addr_full = {cmd_ad, addr_lo};
    assign addr_hit  = ((addr_full ^ `CSM_CMD_ADDR) & `CSM_CMD_MASK) == 16'h0000;

    // byte sequencing
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state   <= cmd_seq_pkg::DS_IDLE;
            match_r <= 1'b0;
            cmd_we  <= 1'b0;
        end else begin
            cmd_we <= 1'b0;                           // pulse by default
            if (cmd_stb) begin
                state   <= cmd_seq_pkg::DS_ADDR_HI;   // restart in any state
                match_r <= 1'b0;
            end else begin
                case (state)
                    cmd_seq_pkg::DS_ADDR_HI: begin
                        match_r <= addr_hit;          // decide before data
                        state   <= cmd_seq_pkg::DS_DATA;
                    end
                    cmd_seq_pkg::DS_DATA: begin
                        cmd_we  <= match_r;           // only our address
                        match_r <= 1'b0;
                        state   <= cmd_seq_pkg::DS_IDLE;
                    end
                    default: begin
                        state <= cmd_seq_pkg::DS_IDLE;
                    end
                endcase
            end
        end
    end

    // byte capture
    always_ff @(posedge mclk) begin
        if (cmd_stb) begin
            addr_lo <= cmd_ad;                        // first byte
        end
        if (!cmd_stb && (state == cmd_seq_pkg::DS_DATA) && match_r) begin
            cmd_data <= cmd_ad;                       // keep previous on mismatch
        end
    end

endmodule

`default_nettype wire

// ==== src/cmd_seq_arbiter.sv ====
/*
 * cmd_seq_arbiter
 * round robin pick among channel writes, one registered output slot
 */
`timescale 1ns/1ps
`default_nettype none

`include "cmd_seq_consts.svh"

module cmd_seq_arbiter (
    input  logic                                   mclk,
    input  logic                                   rst,
    input  cmd_seq_pkg::seq_wr_t [`CSM_NUM_CHN-1:0] chn_wr,    // per channel write
    input  logic                 [`CSM_NUM_CHN-1:0] wr_en,     // level requests
    output logic                 [`CSM_NUM_CHN-1:0] ackn,      // one cycle accept
    output cmd_seq_pkg::seq_wr_t                   out_wr,    // selected write
    output logic                                   wr_en_out, // out_wr valid
    input  logic                                   ackn_out,  // downstream took it
    output logic                                   any_req    // someone is waiting
);

    localparam int CHN_BITS = $clog2(`CSM_NUM_CHN);

    logic [`CSM_NUM_CHN-1:0] req;     // requests not yet acknowledged
    logic [`CSM_NUM_CHN-1:0] grant;   // one-hot of sel
    logic [CHN_BITS-1:0]     chn_r;   // last served channel
    logic [CHN_BITS-1:0]     sel;     // next channel to serve
    logic                    full_r;  // output slot occupied
    logic                    take;    // load slot this edge

    // a channel still sees its ackn this cycle, skip it
    assign req       = wr_en & ~ackn;
    assign any_req   = |req;
    assign take      = any_req && (!full_r || ackn_out);  // no bubble on ackn_out
    assign wr_en_out = full_r;

    // first requester after chn_r, searching upward with wrap
    always_comb begin : rr_pick
        logic [CHN_BITS-1:0] idx;
        logic                found;
        sel   = chn_r;
        found = 1'b0;
        for (int i = 1; i <= `CSM_NUM_CHN; i++) begin
            idx = chn_r + CHN_BITS'(i);                   // wraps at channel count
            if (req[idx] && !found) begin
                sel   = idx;
                found = 1'b1;
            end
        end
    end

    always_comb begin
        grant      = '0;
        grant[sel] = 1'b1;
    end

    // control state
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            full_r <= 1'b0;
            ackn   <= '0;
            chn_r  <= CHN_BITS'(`CSM_NUM_CHN - 1);        // channel 0 goes first
        end else begin
            if (take) begin
                full_r <= 1'b1;                           // refilled or newly filled
            end else if (ackn_out) begin
                full_r <= 1'b0;                           // drained, nothing waiting
            end
            ackn <= take ? grant : '0;                    // pulse with output valid
            if (take) begin
                chn_r <= sel;
            end
        end
    end

    // output payload, held while slot is full and not acknowledged
    always_ff @(posedge mclk) begin
        if (take) begin
            out_wr <= chn_wr[sel];
        end
    end

endmodule

`default_nettype wire

// ==== src/cmd_seq_mux.sv ====
/*
 * cmd_seq_mux
 * four channel command write mux with status reporting on the ring
 */
`timescale 1ns/1ps
`default_nettype none

`include "cmd_seq_consts.svh"

module cmd_seq_mux (
    input  logic                                   mclk,
    input  logic                                   rst,
    // programming port
    input  logic                 [7:0]             cmd_ad,       // addr lo, addr hi, data
    input  logic                                   cmd_stb,      // with addr lo
    // status ring
    output logic                 [7:0]             status_ad,
    output logic                                   status_rq,
    input  logic                                   status_start,
    // sensor channels
    input  logic                 [`CSM_NUM_CHN-1:0][3:0] frame_num,  // per channel frame
    input  cmd_seq_pkg::seq_wr_t [`CSM_NUM_CHN-1:0] chn_wr,
    input  logic                 [`CSM_NUM_CHN-1:0] wr_en,
    output logic                 [`CSM_NUM_CHN-1:0] ackn,
    // command bus
    output cmd_seq_pkg::seq_wr_t                   out_wr,
    output logic                                   wr_en_out,
    input  logic                                   ackn_out
);

    logic [7:0]  cmd_data;   // status command byte
    logic        cmd_we;
    logic        any_req;    // pending channel writes
    logic [17:0] payload;    // frames 3..0, any_req, wr_en_out

    assign payload = {frame_num, any_req, wr_en_out};

    cmd_deser u_cmd_deser (
        .mclk     (mclk),
        .rst      (rst),
        .cmd_ad   (cmd_ad),
        .cmd_stb  (cmd_stb),
        .cmd_data (cmd_data),
        .cmd_we   (cmd_we)
    );

    cmd_seq_arbiter u_arbiter (
        .mclk      (mclk),
        .rst       (rst),
        .chn_wr    (chn_wr),
        .wr_en     (wr_en),
        .ackn      (ackn),
        .out_wr    (out_wr),
        .wr_en_out (wr_en_out),
        .ackn_out  (ackn_out),
        .any_req   (any_req)
    );

    status_generate u_status (
        .mclk         (mclk),
        .rst          (rst),
        .cmd_we       (cmd_we),
        .cmd_data     (cmd_data),
        .payload      (payload),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start)
    );

endmodule

`default_nettype wire

// ==== src/cmd_seq_pkg.sv ====
/*
 * cmd_seq_pkg
 * shared types of the command sequencer mux: write struct and enums
 */
`default_nettype none

`include "cmd_seq_consts.svh"

package cmd_seq_pkg;

    // one sequencer register write
    typedef struct packed {
        logic [`CSM_WADDR_BITS-1:0] waddr;  // register address
        logic [31:0]                wdata;  // register data
    } seq_wr_t;

    // status reporting mode, low two bits of the status command
    typedef enum logic [1:0] {
        STATUS_OFF  = 2'b00,  // silent
        STATUS_ONCE = 2'b01,  // one packet then off
        STATUS_RSVD = 2'b10,  // behaves as off
        STATUS_AUTO = 2'b11   // packet on every payload change
    } status_mode_e;

    // command deserializer states
    typedef enum logic [1:0] {
        DS_IDLE    = 2'b00,  // waiting for strobe
        DS_ADDR_HI = 2'b01,  // next byte is address high
        DS_DATA    = 2'b10   // next byte is data
    } deser_state_e;

    // status packet sender states
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_REQ  = 2'b01,  // address byte offered to ring
        ST_SEND = 2'b10   // payload bytes going out
    } stat_state_e;

endpackage

`default_nettype wire

// ==== src/status_generate.sv ====
/*
 * status_generate
 * status mode register and byte serial status packet sender
 */
`timescale 1ns/1ps
`default_nettype none

`include "cmd_seq_consts.svh"

module status_generate (
    input  logic        mclk,
    input  logic        rst,
    input  logic        cmd_we,        // status command strobe
    input  logic [7:0]  cmd_data,      // {seq, mode}
    input  logic [17:0] payload,       // live status bits
    output logic [7:0]  status_ad,     // addr byte, then three data bytes
    output logic        status_rq,     // request to ring
    input  logic        status_start   // ring accepted addr byte
);

    cmd_seq_pkg::status_mode_e mode;
    cmd_seq_pkg::status_mode_e cmd_mode;
    cmd_seq_pkg::stat_state_e  state;

    logic [5:0]  seq;        // sequence tag from command
    logic [17:0] last_sent;  // payload of the last packet
    logic [23:0] pkt_sh;     // outgoing bytes with low byte first
    logic [1:0]  byte_cnt;
    logic        cmd_trig;   // command asks for a packet
    logic        cmd_pend;   // command arrived while busy
    logic        auto_en;
    logic        auto_chg;   // auto mode and payload moved

    assign cmd_mode = cmd_seq_pkg::status_mode_e'(cmd_data[1:0]);
    assign cmd_trig = cmd_we && ((cmd_mode == cmd_seq_pkg::STATUS_ONCE) ||
                                 (cmd_mode == cmd_seq_pkg::STATUS_AUTO));

    always_comb begin
        case (mode)
            cmd_seq_pkg::STATUS_AUTO: auto_en = 1'b1;
            default:                  auto_en = 1'b0;    // rsvd acts as off
        endcase
    end

    assign auto_chg  = auto_en && (payload != last_sent);
    assign status_rq = (state == cmd_seq_pkg::ST_REQ);
    assign status_ad = (state == cmd_seq_pkg::ST_SEND) ? pkt_sh[7:0] : `CSM_STATUS_ADDR;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            mode     <= cmd_seq_pkg::STATUS_OFF;
            seq      <= '0;
            state    <= cmd_seq_pkg::ST_IDLE;
            byte_cnt <= '0;
            cmd_pend <= 1'b0;
        end else begin
            if (cmd_we) begin
                mode <= cmd_mode;                        // command wins over once-clear
                seq  <= cmd_data[7:2];
            end else if (status_rq && status_start &&
                         (mode == cmd_seq_pkg::STATUS_ONCE)) begin
                mode <= cmd_seq_pkg::STATUS_OFF;        // single shot done
            end
            if (state == cmd_seq_pkg::ST_IDLE) begin
                cmd_pend <= 1'b0;                        // idle serves it directly
            end else if (cmd_trig) begin
                cmd_pend <= 1'b1;
            end
            case (state)
                cmd_seq_pkg::ST_IDLE: begin
                    if (cmd_trig || cmd_pend || auto_chg) begin
                        state <= cmd_seq_pkg::ST_REQ;
                    end
                end
                cmd_seq_pkg::ST_REQ: begin
                    byte_cnt <= '0;
                    if (status_start) begin
                        state <= cmd_seq_pkg::ST_SEND;
                    end
                end
                cmd_seq_pkg::ST_SEND: begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (byte_cnt == 2'd2) begin
                        state <= cmd_seq_pkg::ST_IDLE;  // third data byte out
                    end
                end
                default: state <= cmd_seq_pkg::ST_IDLE;
            endcase
        end
    end

    // packet data sampled when the ring takes the addr byte
    always_ff @(posedge mclk) begin
        if (status_rq && status_start) begin
            pkt_sh    <= {payload[17:2], seq, payload[1:0]};
            last_sent <= payload;                        // reference for auto mode
        end else if (state == cmd_seq_pkg::ST_SEND) begin
            pkt_sh <= {8'h00, pkt_sh[23:8]};            // next byte down
        end
    end

endmodule

`default_nettype wire
